/* hdl/icache_pkg.sv */
/*
 * icache shared definitions
 * geometry, address field types, channel structs and controller states
 */
package icache_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int WAYS       = 4;
    localparam int SETS       = 64;
    localparam int LINE_WORDS = 4;
    localparam int OFFSET_W   = 4;                          // byte offset in a line
    localparam int INDEX_W    = 6;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W; // 22

    localparam logic [2:0] ARPROT_INSN = 3'b100; // unprivileged, secure, instruction

    typedef logic [ADDR_W-1:0]       addr_t;
    typedef logic [DATA_W-1:0]       word_t;
    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [INDEX_W-1:0]      index_t;
    typedef logic [$clog2(WAYS)-1:0] way_t;
    typedef logic [WAYS-1:0]         way_mask_t;
    typedef word_t [LINE_WORDS-1:0]  line_t;   // word 0 in the low bits

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef struct packed {
        addr_t addr;
        logic  cacheable;
    } cpu_req_t;

    typedef struct packed {
        addr_t      araddr;
        logic [2:0] arprot;
    } ar_chan_t;

    typedef struct packed {
        word_t      rdata;
        logic [1:0] rresp;
    } r_chan_t;

    typedef struct packed {
        addr_t addr;
        logic  line;   // 1 = four-word line, 0 = single word
    } fetch_cmd_t;

    typedef enum logic [2:0] {
        LOOKUP,
        MISS_FETCH,
        FILL_WRITE,
        UNCACHED_FETCH,
        UNCACHED_DONE
    } ctrl_state_t;

endpackage

/* hdl/icache_way_store.sv */
/*
 * icache way store
 * tag, valid and line data for one way
 * synchronous read every cycle, whole-line write on refill
 */
`timescale 1ns/1ps

module icache_way_store
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  index_t rd_index,
    input  index_t wr_index,
    input  logic   we,
    input  tag_t   tag_wdata,
    input  line_t  line_wdata,
    output tagv_t  tagv,
    output line_t  line
);

    tag_t            tag_mem  [SETS];
    line_t           line_mem [SETS];
    logic [SETS-1:0] valid_q;

    // valid bits and tag/valid read port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            tagv    <= '0;
        end else begin
            if (we) begin
                valid_q[wr_index] <= 1'b1;
            end
            tagv.valid <= valid_q[rd_index];
            tagv.tag   <= tag_mem[rd_index];
        end
    end

    // storage arrays, written as a whole line
    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[wr_index]  <= tag_wdata;
            line_mem[wr_index] <= line_wdata;
        end
        line <= line_mem[rd_index]; // old data on same-set write
    end

endmodule

/* hdl/icache_plru.sv */
/*
 * icache tree pseudo-LRU
 * one 3-bit tree per set, bit 0 is the root
 * bit 1 picks inside ways 0/1, bit 2 inside ways 2/3
 */
`timescale 1ns/1ps

module icache_plru
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   update,
    input  index_t upd_index,
    input  way_t   upd_way,
    input  index_t query_index,
    output way_t   victim
);

    logic [SETS-1:0][2:0] tree_q;
    logic [2:0]           tree_next;
    logic [2:0]           tree_query;

    // point every node on the accessed path away from it
    always_comb begin
        tree_next    = tree_q[upd_index];
        tree_next[0] = ~upd_way[1];
        if (!upd_way[1]) begin
            tree_next[1] = ~upd_way[0];
        end else begin
            tree_next[2] = ~upd_way[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tree_q <= '0;
        end else if (update) begin
            tree_q[upd_index] <= tree_next;
        end
    end

    // walk from the root
    assign tree_query = tree_q[query_index];
    assign victim[1]  = tree_query[0];
    assign victim[0]  = tree_query[0] ? tree_query[2] : tree_query[1];

    a_upd_way_known: assert property (@(posedge clk) disable iff (!rst_n)
        update |-> !$isunknown(upd_way))
        else $error("plru update with unknown way");

endmodule

/* hdl/icache_axi_reader.sv */
/*
 * icache AXI4-Lite read master
 * one AR then one R per beat, four beats for a line or one for a word
 * beats come back in ascending address order
 */
`timescale 1ns/1ps

module icache_axi_reader
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  fetch_cmd_t cmd,
    input  logic       cmd_valid,
    output logic       busy,
    output ar_chan_t   ar,
    output logic       arvalid,
    input  logic       arready,
    input  r_chan_t    r,
    input  logic       rvalid,
    output logic       rready,
    output word_t      beat_data,
    output logic       beat_valid,
    output logic       beat_last
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    typedef logic [$clog2(LINE_WORDS)-1:0] beat_cnt_t;

    rd_state_t state_q;
    beat_cnt_t beat_cnt_q;
    beat_cnt_t last_cnt_q;   // index of the final beat
    addr_t     addr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= RD_IDLE;
            beat_cnt_q <= '0;
            last_cnt_q <= '0;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    if (cmd_valid) begin
                        state_q    <= RD_ADDR;
                        beat_cnt_q <= '0;
                        last_cnt_q <= cmd.line ? beat_cnt_t'(LINE_WORDS - 1) : '0;
                    end
                end
                RD_ADDR: begin
                    if (arready) begin
                        state_q <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (rvalid) begin
                        if (beat_last) begin
                            state_q <= RD_IDLE;
                        end else begin
                            state_q    <= RD_ADDR; // next word of the line
                            beat_cnt_q <= beat_cnt_q + 1'b1;
                        end
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    // fetch address, steps one word per beat
    always_ff @(posedge clk) begin
        if (state_q == RD_IDLE && cmd_valid) begin
            addr_q <= cmd.addr;
        end else if (state_q == RD_DATA && rvalid) begin
            addr_q <= addr_q + ADDR_W'(4);
        end
    end

    assign busy       = (state_q != RD_IDLE);
    assign arvalid    = (state_q == RD_ADDR);
    assign ar.araddr  = addr_q;
    assign ar.arprot  = ARPROT_INSN;
    assign rready     = 1'b1;
    assign beat_data  = r.rdata;
    assign beat_valid = (state_q == RD_DATA) && rvalid;
    assign beat_last  = beat_valid && (beat_cnt_q == last_cnt_q);

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("AR dropped or changed before arready");

    a_cmd_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid |-> !busy)
        else $error("fetch command while reader busy");

endmodule

/* hdl/icache_ctrl.sv */
/*
 * icache controller
 * request register, tag compare and word select
 * miss refill into the victim way and uncached bypass
 */
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_req_t              req,
    input  logic                  req_valid,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output word_t                 rsp_data,
    output index_t                way_rd_index,
    output index_t                way_wr_index,
    output way_mask_t             way_we,
    output tag_t                  fill_tag,
    output line_t                 fill_line,
    input  tagv_t [WAYS-1:0]      way_tagv,
    input  line_t [WAYS-1:0]      way_line,
    output logic                  plru_update,
    output way_t                  plru_way,
    input  way_t                  plru_victim,
    output fetch_cmd_t            cmd,
    output logic                  cmd_valid,
    input  word_t                 beat_data,
    input  logic                  beat_valid,
    input  logic                  beat_last
);

    ctrl_state_t                   state_q;
    cpu_req_t                      req_q;
    logic                          req_q_valid;
    tag_t                          req_tag;
    index_t                        req_index;
    logic [$clog2(LINE_WORDS)-1:0] word_sel;
    logic [$clog2(LINE_WORDS)-1:0] fill_cnt_q;
    way_mask_t                     hit;
    way_t                          hit_way;
    way_t                          fill_way;
    way_t                          victim_q;
    line_t                         fill_line_q;
    logic                          lookup_hit;
    logic                          lookup_miss; // miss or uncached, leaves LOOKUP
    logic                          accept;

    assign req_tag   = req_q.addr[ADDR_W-1 -: TAG_W];
    assign req_index = req_q.addr[OFFSET_W +: INDEX_W];
    assign word_sel  = req_q.addr[OFFSET_W-1:2];

    always_comb begin
        hit     = '0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit[w] = way_tagv[w].valid && (way_tagv[w].tag == req_tag);
            if (hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // empty ways fill first, lowest number wins
    always_comb begin
        fill_way = plru_victim;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!way_tagv[w].valid) begin
                fill_way = way_t'(w);
            end
        end
    end

    assign lookup_hit  = (state_q == LOOKUP) && req_q_valid && req_q.cacheable && (|hit);
    assign lookup_miss = (state_q == LOOKUP) && req_q_valid && !lookup_hit;
    assign req_ready   = (state_q == LOOKUP || state_q == UNCACHED_DONE) && !lookup_miss;
    assign accept      = req_valid && req_ready;

    // stalled: keep reading the pending set
    assign way_rd_index = req_ready ? req.addr[OFFSET_W +: INDEX_W] : req_index;
    assign way_wr_index = req_index;
    assign way_we       = (state_q == FILL_WRITE) ? way_mask_t'(1) << victim_q : '0;
    assign fill_tag     = req_tag;
    assign fill_line    = fill_line_q;

    assign plru_update = lookup_hit || (state_q == FILL_WRITE);
    assign plru_way    = (state_q == FILL_WRITE) ? victim_q : hit_way;

    assign cmd_valid = lookup_miss;
    assign cmd.line  = req_q.cacheable;
    assign cmd.addr  = req_q.cacheable ? {req_tag, req_index, OFFSET_W'(0)}
                                       : {req_q.addr[ADDR_W-1:2], 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= LOOKUP;
            req_q_valid <= 1'b0;
            rsp_valid   <= 1'b0;
            fill_cnt_q  <= '0;
        end else begin
            req_q_valid <= accept;
            rsp_valid   <= lookup_hit || (state_q == FILL_WRITE)
                           || (state_q == UNCACHED_FETCH && beat_valid);
            if (state_q == MISS_FETCH && beat_valid) begin
                fill_cnt_q <= fill_cnt_q + 1'b1; // wraps after the last beat
            end
            case (state_q)
                LOOKUP: begin
                    if (lookup_miss) begin
                        state_q <= req_q.cacheable ? MISS_FETCH : UNCACHED_FETCH;
                    end
                end
                MISS_FETCH: begin
                    if (beat_valid && beat_last) begin
                        state_q <= FILL_WRITE;
                    end
                end
                FILL_WRITE:     state_q <= LOOKUP;
                UNCACHED_FETCH: begin
                    if (beat_valid) begin
                        state_q <= UNCACHED_DONE;
                    end
                end
                UNCACHED_DONE:  state_q <= LOOKUP;
                default:        state_q <= LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (lookup_miss) begin
            victim_q <= fill_way;
        end
        if (state_q == MISS_FETCH && beat_valid) begin
            fill_line_q[fill_cnt_q] <= beat_data;
        end
        if (lookup_hit) begin
            rsp_data <= way_line[hit_way][word_sel];
        end else if (state_q == FILL_WRITE) begin
            rsp_data <= fill_line_q[word_sel]; // requested word from the new line
        end else if (state_q == UNCACHED_FETCH && beat_valid) begin
            rsp_data <= beat_data;
        end
    end

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == LOOKUP) && req_q_valid |-> $onehot0(hit))
        else $error("tag matches in more than one way");

    a_no_rsp_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == MISS_FETCH) |-> !rsp_valid)
        else $error("response during line fetch");

endmodule

/* hdl/icache_top.sv */
/*
 * icache top level
 * 4-way instruction cache with AXI4-Lite read master
 */
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  cpu_req_t req,
    input  logic     req_valid,
    output logic     req_ready,
    output logic     rsp_valid,
    output word_t    rsp_data,
    output ar_chan_t ar,
    output logic     arvalid,
    input  logic     arready,
    input  r_chan_t  r,
    input  logic     rvalid,
    output logic     rready
);

    index_t           way_rd_index;
    index_t           way_wr_index;   // also the PLRU set
    way_mask_t        way_we;
    tag_t             fill_tag;
    line_t            fill_line;
    tagv_t [WAYS-1:0] way_tagv;
    line_t [WAYS-1:0] way_line;
    logic             plru_update;
    way_t             plru_way;
    way_t             plru_victim;
    fetch_cmd_t       cmd;
    logic             cmd_valid;
    word_t            beat_data;
    logic             beat_valid;
    logic             beat_last;

    generate
        for (genvar w = 0; w < WAYS; w++) begin : g_way
            icache_way_store u_way (
                .clk        (clk),
                .rst_n      (rst_n),
                .rd_index   (way_rd_index),
                .wr_index   (way_wr_index),
                .we         (way_we[w]),
                .tag_wdata  (fill_tag),
                .line_wdata (fill_line),
                .tagv       (way_tagv[w]),
                .line       (way_line[w])
            );
        end
    endgenerate

    icache_plru u_plru (
        .clk         (clk),
        .rst_n       (rst_n),
        .update      (plru_update),
        .upd_index   (way_wr_index),
        .upd_way     (plru_way),
        .query_index (way_wr_index),
        .victim      (plru_victim)
    );

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .rsp_valid    (rsp_valid),
        .rsp_data     (rsp_data),
        .way_rd_index (way_rd_index),
        .way_wr_index (way_wr_index),
        .way_we       (way_we),
        .fill_tag     (fill_tag),
        .fill_line    (fill_line),
        .way_tagv     (way_tagv),
        .way_line     (way_line),
        .plru_update  (plru_update),
        .plru_way     (plru_way),
        .plru_victim  (plru_victim),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .beat_data    (beat_data),
        .beat_valid   (beat_valid),
        .beat_last    (beat_last)
    );

    icache_axi_reader u_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .busy       (),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .r          (r),
        .rvalid     (rvalid),
        .rready     (rready),
        .beat_data  (beat_data),
        .beat_valid (beat_valid),
        .beat_last  (beat_last)
    );

endmodule

/* verif/axi_lite_mem_model.sv */
/*
 * AXI4-Lite read slave for the icache testbench
 * one R beat per AR, each after a random wait of 0 to 3 cycles
 * read data for address A is (A ^ 32'h5a5a_0000) + A rotated left by 8
 */
`timescale 1ns/1ps

module axi_lite_mem_model
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  ar_chan_t ar,
    input  logic     arvalid,
    output logic     arready,
    output r_chan_t  r,
    output logic     rvalid,
    input  logic     rready
);

    localparam word_t DATA_XOR = 32'h5a5a_0000;

    logic [1:0] ar_wait_q;
    logic [1:0] r_wait_q;
    logic       r_pending_q;   // address taken, data not sent yet
    addr_t      addr_q;

    function automatic word_t mem_word(input addr_t a);
        return (a ^ DATA_XOR) + {a[23:0], a[31:24]};
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready     <= 1'b0;
            rvalid      <= 1'b0;
            r           <= '0;
            r_pending_q <= 1'b0;
            ar_wait_q   <= '0;
            r_wait_q    <= '0;
            addr_q      <= '0;
        end else begin
            if (arvalid && arready) begin
                arready     <= 1'b0;
                addr_q      <= ar.araddr;
                r_pending_q <= 1'b1;
                r_wait_q    <= 2'($urandom);
                ar_wait_q   <= 2'($urandom); // wait for the next address
            end else if (arvalid && !r_pending_q && !rvalid) begin
                if (ar_wait_q == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait_q <= ar_wait_q - 2'd1;
                end
            end
            if (r_pending_q) begin
                if (r_wait_q == 2'd0) begin
                    rvalid      <= 1'b1;
                    r.rdata     <= mem_word(addr_q);
                    r.rresp     <= 2'b00;   // OKAY
                    r_pending_q <= 1'b0;
                end else begin
                    r_wait_q <= r_wait_q - 2'd1;
                end
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

/* verif/icache_tb.sv */
/*
 * icache testbench
 * replays the golden fetch list against the cache and an AXI4-Lite memory
 * checks data, AR count and addresses, hit latency and miss stalls
 */
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    localparam int    CLK_NS       = 10;
    localparam int    RESET_CYCLES = 3;
    localparam int    NS_PER_TEST  = 300;
    localparam string GOLDEN_FILE  = "verif/icache_golden.txt";

    logic     clk;
    logic     rst_n;
    cpu_req_t req;
    logic     req_valid;
    logic     req_ready;
    logic     rsp_valid;
    word_t    rsp_data;
    ar_chan_t ar;
    logic     arvalid;
    logic     arready;
    r_chan_t  r;
    logic     rvalid;
    logic     rready;

    addr_t       gold_addr  [$];
    logic        gold_cache [$];
    word_t       gold_data  [$];
    int unsigned gold_ars   [$];
    int          n_tests;
    logic        loaded;

    int          pend_test  [$];  // accepted with the response still due
    int unsigned pend_cycle [$];
    addr_t       ar_seen    [$];  // AR addresses since the last response
    int unsigned cycle;
    int          accept_count;
    int          rsp_count;
    int          rsp_test;
    int          pass_count;
    int          fail_count;
    int          other_errs;
    logic        stall_check;     // miss in flight
    logic        hit_check;       // hit accepted on the last edge

    icache_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    axi_lite_mem_model u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic read_golden();
        int          fd;
        int          n;
        string       text;
        addr_t       a;
        logic [31:0] c;
        word_t       d;
        logic [31:0] k;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", GOLDEN_FILE);
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(text, fd);
            if (n > 0 && text[0] != "#") begin   // skip column notes
                if ($sscanf(text, "%h %h %h %h", a, c, d, k) == 4) begin
                    gold_addr.push_back(a);
                    gold_cache.push_back(c[0]);
                    gold_data.push_back(d);
                    gold_ars.push_back(k);
                end
            end
        end
        $fclose(fd);
        n_tests = gold_addr.size();
    endtask

    // present one fetch and return on the edge that accepts it
    task automatic send_request(input int t);
        req.addr      <= gold_addr[t];
        req.cacheable <= gold_cache[t];
        req_valid     <= 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic check_response(input int t, input int unsigned acc_cycle);
        int    errs;
        addr_t a;
        addr_t exp_ar;
        errs = 0;
        a    = gold_addr[t];
        assert (rsp_data == gold_data[t])
            else begin
                $display("Fail rsp_data exp %h got %h", gold_data[t], rsp_data);
                errs++;
            end
        assert (ar_seen.size() == gold_ars[t])
            else begin
                $display("Fail ar_count exp %h got %h", gold_ars[t], ar_seen.size());
                errs++;
            end
        for (int k = 0; k < ar_seen.size(); k++) begin
            exp_ar = gold_cache[t] ? {a[31:4], 4'h0} + addr_t'(4 * k) : {a[31:2], 2'b00};
            assert (ar_seen[k] == exp_ar)
                else begin
                    $display("Fail araddr exp %h got %h", exp_ar, ar_seen[k]);
                    errs++;
                end
        end
        if (gold_ars[t] == 0) begin
            assert (cycle == acc_cycle + 2)   // one cycle after the accepting edge
                else begin
                    $display("hit response came %0d cycles after acceptance",
                             cycle - acc_cycle - 1);
                    errs++;
                end
        end else begin
            assert (req_ready)
                else begin
                    $display("req_ready still low when the miss response arrived");
                    errs++;
                end
        end
        ar_seen.delete();
        if (errs == 0) begin
            pass_count++;
            $display("test %0d addr %h ok", t, a);
        end else begin
            fail_count++;
            $display("test %0d addr %h failed with %0d errors", t, a, errs);
        end
    endtask

    // sampled mid-cycle with every DUT output settled
    always @(negedge clk) begin
        if (rst_n) begin
            cycle++;
            if (arvalid && arready) begin
                ar_seen.push_back(ar.araddr);
                assert (ar.arprot[2])   // instruction access
                    else begin
                        $display("Fail arprot[2] exp 1 got %h", ar.arprot[2]);
                        other_errs++;
                    end
            end
            assert (rready)
                else begin
                    $display("Fail rready exp 1 got %h", rready);
                    other_errs++;
                end
            assert (!rsp_valid || pend_test.size() > 0)
                else begin
                    $display("response with no request pending");
                    other_errs++;
                end
            if (rsp_valid && pend_test.size() > 0) begin
                rsp_test = pend_test.pop_front();
                check_response(rsp_test, pend_cycle.pop_front());
                rsp_count++;
                if (gold_ars[rsp_test] != 0) begin
                    stall_check = 1'b0;
                end
            end
            if (stall_check) begin
                assert (!req_ready)
                    else begin
                        $display("req_ready high while a miss is in flight");
                        other_errs++;
                    end
            end
            if (hit_check) begin
                assert (req_ready)
                    else begin
                        $display("req_ready low in the cycle after a hit was accepted");
                        other_errs++;
                    end
            end
            if (req_valid && req_ready) begin
                pend_test.push_back(accept_count);
                pend_cycle.push_back(cycle);
                stall_check = (gold_ars[accept_count] != 0);
                hit_check   = gold_cache[accept_count] && (gold_ars[accept_count] == 0);
                accept_count++;
            end else begin
                hit_check = 1'b0;
            end
        end
    end

    initial begin
        wait (loaded);
        #(n_tests * NS_PER_TEST + (RESET_CYCLES + 2) * CLK_NS);
        $display("timeout with %0d of %0d responses at %0t", rsp_count, n_tests, $time);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'hbaefc8cb));
        clk          = 1'b0;
        rst_n        = 1'b0;
        req          = '0;
        req_valid    = 1'b0;
        cycle        = 0;
        accept_count = 0;
        rsp_count    = 0;
        rsp_test     = 0;
        pass_count   = 0;
        fail_count   = 0;
        other_errs   = 0;
        stall_check  = 1'b0;
        hit_check    = 1'b0;
        n_tests      = 0;
        read_golden();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int t = 0; t < n_tests; t++) begin
            send_request(t);
            // a hit lets the next fetch follow on the very next edge
            if (!(gold_cache[t] && gold_ars[t] == 0)) begin
                req_valid <= 1'b0;
                while (rsp_count <= t) begin
                    @(posedge clk);
                end
            end
        end
        req_valid <= 1'b0;
        while (rsp_count < n_tests) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);   // catch stray responses
        $display("tests passed %0d failed %0d, other errors %0d",
                 pass_count, fail_count, other_errs);
        if (fail_count == 0 && other_errs == 0 && n_tests > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verif/icache_golden.txt */
# columns: address, cacheable flag, expected data, expected AR transfers (all hex)
# sets 1 to 3 cover miss, hit and uncached, set 5 covers PLRU replacement
00000014 1 5a5a1414 4
0000001c 1 5a5a1c1c 0
00000010 1 5a5a1010 0
00002024 1 5a7a4424 4
00002028 1 5a7a4828 0
00000034 0 5a5a3434 1
00000034 0 5a5a3434 1
00000038 1 5a5a3838 4
00000036 0 5a5a3434 1
0000003c 1 5a5a3c3c 0
00000450 1 5a5e5450 4
00000850 1 5a625850 4
00000c50 1 5a665c50 4
00001050 1 5a6a6050 4
00000454 1 5a5e5854 0
00000858 1 5a626058 0
00000c5c 1 5a66685c 0
00001058 1 5a6a6858 0
00001450 1 5a6e6450 4
00000450 1 5a5e5450 4
0000105c 1 5a6a6c5c 0
00000c50 1 5a665c50 4

/* icache_top.f */
hdl/icache_pkg.sv
hdl/icache_way_store.sv
hdl/icache_plru.sv
hdl/icache_axi_reader.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
verif/axi_lite_mem_model.sv
verif/icache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f icache_top.f --top-module icache_tb -o icache_sim \
    && ./obj_dir/icache_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "^TEST PASS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
